// ==== Makefile ====
# Verilator build and run for the vector back end testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_rvv_backend
FILELIST := files.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := Finished with no errors
SRCS     := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation FAILED"; exit 1; }
	@echo "simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
hdl/rvv_cfg_pkg.sv
hdl/rvv_uop_pkg.sv
hdl/rvv_dispatch.sv
hdl/rvv_exec_lane.sv
hdl/rvv_rob.sv
hdl/rvv_backend.sv
sim/tb_rvv_backend.sv

// ==== hdl/rvv_backend.sv ====
/*
  Top of the vector result back end.
  One dispatcher feeds NUM_LANES execution lanes, and the ROB collects
  their results and retires them in program order.
*/
module rvv_backend #(
  parameter int NUM_LANES = 3
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          uop_valid,
  input  rvv_uop_pkg::uop_t                             uop,
  output logic                                          uop_ready,
  output logic [rvv_cfg_pkg::RT_WIDTH-1:0]              rt_valid,
  output rvv_uop_pkg::rob_rt_t [rvv_cfg_pkg::RT_WIDTH-1:0] rt_rec,
  input  logic [rvv_cfg_pkg::RT_WIDTH-1:0]              rt_ready,
  input  logic                                          trap_valid,
  input  rvv_uop_pkg::trap_t                            trap,
  output logic                                          trap_ready
);
  import rvv_cfg_pkg::*;
  import rvv_uop_pkg::*;

  logic                          rob_full;
  logic [ROB_IDX_W-1:0]          alloc_idx;
  logic                          alloc;
  logic [NUM_LANES-1:0]          issue_valid;
  logic [NUM_LANES-1:0]          lane_ready;
  logic [NUM_LANES-1:0]          res_valid;
  issue_t                        issue;
  lane_res_t [NUM_LANES-1:0]     res;
  logic                          flush;

  rvv_dispatch #(.NUM_LANES(NUM_LANES)) u_dispatch (
    .clk         (clk),
    .rst_n       (rst_n),
    .uop_valid   (uop_valid),
    .uop         (uop),
    .uop_ready   (uop_ready),
    .rob_full    (rob_full),
    .alloc_idx   (alloc_idx),
    .alloc       (alloc),
    .issue_valid (issue_valid),
    .issue       (issue),
    .lane_ready  (lane_ready),
    .flush       (flush)
  );

  // issue bus is shared, issue_valid selects the lane
  for (genvar k = 0; k < NUM_LANES; k++) begin : gen_lane
    rvv_exec_lane u_lane (
      .clk         (clk),
      .rst_n       (rst_n),
      .issue_valid (issue_valid[k]),
      .issue       (issue),
      .lane_ready  (lane_ready[k]),
      .res_valid   (res_valid[k]),
      .res         (res[k]),
      .flush       (flush)
    );
  end

  rvv_rob #(.NUM_LANES(NUM_LANES)) u_rob (
    .clk        (clk),
    .rst_n      (rst_n),
    .alloc      (alloc),
    .alloc_uop  (issue.uop),
    .alloc_idx  (alloc_idx),
    .rob_full   (rob_full),
    .res_valid  (res_valid),
    .res        (res),
    .trap_valid (trap_valid),
    .trap       (trap),
    .trap_ready (trap_ready),
    .rt_valid   (rt_valid),
    .rt_rec     (rt_rec),
    .rt_ready   (rt_ready),
    .flush      (flush)
  );

endmodule

// ==== hdl/rvv_cfg_pkg.sv ====
/*
  Sizing constants for the vector back end.
  Shared by the dispatcher, the execution lanes and the reorder buffer,
  and by the uop package that builds its structs from them.
*/
package rvv_cfg_pkg;

  // reorder buffer
  localparam int ROB_DEPTH = 8;
  localparam int ROB_IDX_W = $clog2(ROB_DEPTH);

  // element data path
  localparam int DATA_W = 16;

  // retire lanes per cycle
  localparam int RT_WIDTH = 2;

  // architectural vector register index
  localparam int VREG_W = 5;

  // multiply pipe depth in cycles, must be 2 or more
  localparam int MUL_LAT = 3;

endpackage

// ==== hdl/rvv_dispatch.sv ====
/*
  Single-entry dispatch stage.
  Takes one uop per cycle into a hold register, then allocates the next
  ROB entry and issues the uop to the lowest idle lane in one cycle.
  A flush drops the held uop.
*/
module rvv_dispatch #(
  parameter int NUM_LANES = 3
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               uop_valid,
  input  rvv_uop_pkg::uop_t                  uop,
  output logic                               uop_ready,
  input  logic                               rob_full,
  input  logic [rvv_cfg_pkg::ROB_IDX_W-1:0]  alloc_idx,
  output logic                               alloc,
  output logic [NUM_LANES-1:0]               issue_valid,
  output rvv_uop_pkg::issue_t                issue,
  input  logic [NUM_LANES-1:0]               lane_ready,
  input  logic                               flush
);
  import rvv_uop_pkg::*;

  logic                 hold_valid;
  uop_t                 hold_uop;
  logic [NUM_LANES-1:0] lane_pick;
  logic                 fire;

  // isolate the lowest idle lane
  assign lane_pick = lane_ready & (~lane_ready + NUM_LANES'(1));

  // no issue while a flush clears the ROB
  assign fire = hold_valid & (|lane_ready) & ~rob_full & ~flush;

  assign alloc       = fire;
  assign issue_valid = fire ? lane_pick : '0;
  assign issue       = '{uop: hold_uop, rob_entry: alloc_idx};

  // room when empty or when the held uop leaves this cycle
  assign uop_ready = ~hold_valid | fire | flush;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_valid <= 1'b0;
    end else if (uop_valid && uop_ready) begin
      hold_valid <= 1'b1;
    end else if (fire || flush) begin
      hold_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (uop_valid && uop_ready) begin
      hold_uop <= uop;
    end
  end

  // one lane per uop
  a_issue_onehot: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(issue_valid)
  ) else $error("dispatch issued to more than one lane: %b", issue_valid);

endmodule

// ==== hdl/rvv_exec_lane.sv ====
/*
  One vector execution lane.
  Logic and add ops return a result one cycle after issue, MUL returns
  the low half of the product after MUL_LAT cycles. The lane takes a
  new uop only when idle and drops its work on flush.
*/
module rvv_exec_lane (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    issue_valid,
  input  rvv_uop_pkg::issue_t     issue,
  output logic                    lane_ready,
  output logic                    res_valid,
  output rvv_uop_pkg::lane_res_t  res,
  input  logic                    flush
);
  import rvv_cfg_pkg::*;
  import rvv_uop_pkg::*;

  localparam int CNT_W = $clog2(MUL_LAT);

  typedef enum logic [1:0] {IDLE, BUSY, DONE} state_e;

  state_e            state;
  logic [CNT_W-1:0]  cnt;
  logic [DATA_W:0]   sum_ext;
  logic [DATA_W-1:0] alu_data;
  logic              alu_sat;

  assign lane_ready = (state == IDLE);
  assign res_valid  = (state == DONE);

  // sign-extended sum for the saturating add
  assign sum_ext = {issue.uop.src_a[DATA_W-1], issue.uop.src_a}
                 + {issue.uop.src_b[DATA_W-1], issue.uop.src_b};

  always_comb begin
    alu_sat  = 1'b0;
    alu_data = '0;
    case (issue.uop.op)
      ADD: alu_data = issue.uop.src_a + issue.uop.src_b;
      SUB: alu_data = issue.uop.src_a - issue.uop.src_b;
      AND: alu_data = issue.uop.src_a & issue.uop.src_b;
      XOR: alu_data = issue.uop.src_a ^ issue.uop.src_b;
      SADD: begin
        alu_data = sum_ext[DATA_W-1:0];
        // top two bits differ on signed overflow
        if (sum_ext[DATA_W] != sum_ext[DATA_W-1]) begin
          alu_sat  = 1'b1;
          alu_data = sum_ext[DATA_W] ? {1'b1, {(DATA_W-1){1'b0}}}
                                     : {1'b0, {(DATA_W-1){1'b1}}};
        end
      end
      MUL: alu_data = issue.uop.src_a * issue.uop.src_b;
      default: alu_data = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      cnt   <= '0;
    end else if (flush) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (issue_valid) begin
          if (issue.uop.op == MUL) begin
            state <= BUSY;
            cnt   <= CNT_W'(MUL_LAT - 2);
          end else begin
            state <= DONE;
          end
        end
        BUSY: if (cnt == '0) state <= DONE;
              else cnt <= cnt - CNT_W'(1);
        DONE: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid && lane_ready) begin
      res <= '{rob_entry: issue.rob_entry, w_data: alu_data,
               w_valid: issue.uop.w_valid, vsaturate: alu_sat};
    end
  end

  // dispatcher must respect lane_ready
  a_issue_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    issue_valid |-> lane_ready
  ) else $error("issue to a busy lane");

endmodule

// ==== hdl/rvv_rob.sv ====
/*
  Reorder buffer of the vector back end.
  Allocates entries in program order, collects lane results out of order
  and retires up to RT_WIDTH done entries per cycle from the head.
  A trap notice marks an entry; retiring that entry flushes the ROB,
  the lanes and the dispatcher.
*/
module rvv_rob #(
  parameter int NUM_LANES = 3
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          alloc,
  input  rvv_uop_pkg::uop_t                             alloc_uop,
  output logic [rvv_cfg_pkg::ROB_IDX_W-1:0]             alloc_idx,
  output logic                                          rob_full,
  input  logic [NUM_LANES-1:0]                          res_valid,
  input  rvv_uop_pkg::lane_res_t [NUM_LANES-1:0]        res,
  input  logic                                          trap_valid,
  input  rvv_uop_pkg::trap_t                            trap,
  output logic                                          trap_ready,
  output logic [rvv_cfg_pkg::RT_WIDTH-1:0]              rt_valid,
  output rvv_uop_pkg::rob_rt_t [rvv_cfg_pkg::RT_WIDTH-1:0] rt_rec,
  input  logic [rvv_cfg_pkg::RT_WIDTH-1:0]              rt_ready,
  output logic                                          flush
);
  import rvv_cfg_pkg::*;
  import rvv_uop_pkg::*;

  localparam int NRET_W = $clog2(RT_WIDTH + 1);

  typedef logic [ROB_IDX_W-1:0] idx_t;

  // destination info, written at allocation
  typedef struct packed {
    logic [VREG_W-1:0] vd;
    logic              w_valid;
  } info_t;

  // lane result, written at completion
  typedef struct packed {
    logic [DATA_W-1:0] w_data;
    logic              vsaturate;
  } res_t;

  logic [ROB_DEPTH-1:0] entry_valid;
  logic [ROB_DEPTH-1:0] done;
  logic [ROB_DEPTH-1:0] trap_flag;
  info_t                info_mem [ROB_DEPTH];
  res_t                 res_mem [ROB_DEPTH];
  idx_t                 wptr;
  idx_t                 rptr;
  idx_t                 rt_idx [RT_WIDTH];
  logic [RT_WIDTH-1:0]  rt_take;
  logic [NRET_W-1:0]    n_ret;
  logic                 res_clash;

  assign alloc_idx  = wptr;
  // entries leave in order, so a live entry at wptr means no room
  assign rob_full   = entry_valid[wptr];
  assign trap_ready = 1'b1;

  for (genvar i = 0; i < RT_WIDTH; i++) begin : gen_rt
    assign rt_idx[i] = rptr + idx_t'(i);
    assign rt_rec[i] = '{vd:        info_mem[rt_idx[i]].vd,
                         w_valid:   info_mem[rt_idx[i]].w_valid,
                         w_data:    res_mem[rt_idx[i]].w_data,
                         vsaturate: res_mem[rt_idx[i]].vsaturate,
                         trap_flag: trap_flag[rt_idx[i]]};
  end

  // retire window, a trapped entry closes it behind itself
  always_comb begin
    logic chain;
    chain = 1'b1;
    for (int i = 0; i < RT_WIDTH; i++) begin
      rt_valid[i] = chain & entry_valid[rt_idx[i]] & done[rt_idx[i]];
      chain       = rt_valid[i] & ~trap_flag[rt_idx[i]];
    end
  end

  always_comb begin
    rt_take = rt_valid & rt_ready;
    n_ret   = '0;
    flush   = 1'b0;
    for (int i = 0; i < RT_WIDTH; i++) begin
      if (rt_take[i]) begin
        n_ret = n_ret + NRET_W'(1);
        if (trap_flag[rt_idx[i]]) flush = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      entry_valid <= '0;
      done        <= '0;
      trap_flag   <= '0;
      wptr        <= '0;
      rptr        <= '0;
    end else if (flush) begin
      entry_valid <= '0;
      done        <= '0;
      trap_flag   <= '0;
      wptr        <= '0;
      rptr        <= '0;
    end else begin
      for (int i = 0; i < RT_WIDTH; i++) begin
        if (rt_take[i]) begin
          entry_valid[rt_idx[i]] <= 1'b0;
          done[rt_idx[i]]        <= 1'b0;
          trap_flag[rt_idx[i]]   <= 1'b0;
        end
      end
      if (alloc) begin
        entry_valid[wptr] <= 1'b1;
        done[wptr]        <= 1'b0;
        trap_flag[wptr]   <= 1'b0;
        wptr              <= wptr + idx_t'(1);
      end
      for (int k = 0; k < NUM_LANES; k++) begin
        if (res_valid[k]) done[res[k].rob_entry] <= 1'b1;
      end
      if (trap_valid) trap_flag[trap.trap_rob_entry] <= 1'b1;
      rptr <= rptr + idx_t'(n_ret);
    end
  end

  always_ff @(posedge clk) begin
    if (alloc) begin
      info_mem[wptr] <= '{vd: alloc_uop.vd, w_valid: alloc_uop.w_valid};
    end
    for (int k = 0; k < NUM_LANES; k++) begin
      if (res_valid[k]) begin
        res_mem[res[k].rob_entry] <= '{w_data: res[k].w_data, vsaturate: res[k].vsaturate};
      end
    end
  end

  always_comb begin
    res_clash = 1'b0;
    for (int k = 0; k < NUM_LANES; k++) begin
      for (int j = k + 1; j < NUM_LANES; j++) begin
        if (res_valid[k] && res_valid[j] && res[k].rob_entry == res[j].rob_entry)
          res_clash = 1'b1;
      end
    end
  end

  a_res_unique: assert property (
    @(posedge clk) disable iff (!rst_n)
    !res_clash
  ) else $error("two lanes wrote the same ROB entry");

  // a result matches a live, pending entry and the write intent given at dispatch
  for (genvar k = 0; k < NUM_LANES; k++) begin : gen_res_chk
    a_res_target: assert property (
      @(posedge clk) disable iff (!rst_n)
      res_valid[k] && !flush |->
        entry_valid[res[k].rob_entry] && !done[res[k].rob_entry] &&
        info_mem[res[k].rob_entry].w_valid == res[k].w_valid
    ) else $error("lane %0d result for bad entry %0d", k, res[k].rob_entry);
  end

  // both the offered and the accepted retire lanes start at lane 0
  a_rt_prefix: assert property (
    @(posedge clk) disable iff (!rst_n)
    ((rt_valid & (rt_valid + RT_WIDTH'(1))) == '0) &&
    ((rt_take & (rt_take + RT_WIDTH'(1))) == '0)
  ) else $error("retire lanes not a prefix: valid %b take %b", rt_valid, rt_take);

endmodule

// ==== hdl/rvv_uop_pkg.sv ====
/*
  Opcode and record types of the vector back end.
  uop_t enters at the top, issue_t goes from dispatch to a lane,
  lane_res_t goes from a lane to the ROB, rob_rt_t leaves at retire
  and trap_t is the trap notice from the scalar side.
*/
package rvv_uop_pkg;

  // funct6 style encodings
  typedef enum logic [5:0] {
    ADD  = 6'b000000,
    SUB  = 6'b000010,
    AND  = 6'b001001,
    XOR  = 6'b001011,
    SADD = 6'b100001,
    MUL  = 6'b100101
  } uop_op_e;

  typedef struct packed {
    uop_op_e                          op;
    logic [rvv_cfg_pkg::VREG_W-1:0]   vd;
    logic [rvv_cfg_pkg::DATA_W-1:0]   src_a;
    logic [rvv_cfg_pkg::DATA_W-1:0]   src_b;
    logic                             w_valid;
  } uop_t;

  typedef struct packed {
    uop_t                             uop;
    logic [rvv_cfg_pkg::ROB_IDX_W-1:0] rob_entry;
  } issue_t;

  typedef struct packed {
    logic [rvv_cfg_pkg::ROB_IDX_W-1:0] rob_entry;
    logic [rvv_cfg_pkg::DATA_W-1:0]   w_data;
    logic                             w_valid;
    logic                             vsaturate;
  } lane_res_t;

  typedef struct packed {
    logic [rvv_cfg_pkg::VREG_W-1:0]   vd;
    logic                             w_valid;
    logic [rvv_cfg_pkg::DATA_W-1:0]   w_data;
    logic                             vsaturate;
    logic                             trap_flag;
  } rob_rt_t;

  typedef struct packed {
    logic [rvv_cfg_pkg::ROB_IDX_W-1:0] trap_rob_entry;
  } trap_t;

endpackage

// ==== sim/tb_rvv_backend.sv ====
/*
  Testbench for the vector back end.
  Drives uops, retire ready patterns and trap notices on the falling edge,
  keeps a queue of expected retire records built from the opcode rules,
  and checks every accepted retire record with concurrent assertions.
*/
module tb_rvv_backend;
  import rvv_cfg_pkg::*;
  import rvv_uop_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int UOP_TIMEOUT = 100;
  localparam int RT_LOW      = 0;
  localparam int RT_HIGH     = 1;
  localparam int RT_RAND     = 2;

  typedef struct packed {
    rob_rt_t              rec;
    logic [ROB_IDX_W-1:0] entry;
  } exp_t;

  logic                          clk;
  logic                          rst_n;
  logic                          uop_valid;
  uop_t                          uop;
  logic                          uop_ready;
  logic [RT_WIDTH-1:0]           rt_valid;
  rob_rt_t [RT_WIDTH-1:0]        rt_rec;
  logic [RT_WIDTH-1:0]           rt_ready;
  logic                          trap_valid;
  trap_t                         trap;
  logic                          trap_ready;

  // reference model state
  exp_t                          exp_q[$];
  rob_rt_t [RT_WIDTH-1:0]        exp_rec;
  int                            exp_cnt;
  logic [ROB_IDX_W-1:0]          next_entry;
  int                            dual_seen;
  int                            trap_seen;
  int                            rt_mode;
  int                            trap_rate;

  rvv_backend #(.NUM_LANES(3)) UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .uop_valid  (uop_valid),
    .uop        (uop),
    .uop_ready  (uop_ready),
    .rt_valid   (rt_valid),
    .rt_rec     (rt_rec),
    .rt_ready   (rt_ready),
    .trap_valid (trap_valid),
    .trap       (trap),
    .trap_ready (trap_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic announce_fail();
    $display("Finished with errors");
  endtask

  // retire record the opcode rules give for one uop
  function automatic rob_rt_t expected_record(uop_t u);
    rob_rt_t             r;
    int                  sum;
    logic [2*DATA_W-1:0] prod;
    r = '0;
    r.vd = u.vd;
    r.w_valid = u.w_valid;
    case (u.op)
      ADD: r.w_data = u.src_a + u.src_b;
      SUB: r.w_data = u.src_a - u.src_b;
      AND: r.w_data = u.src_a & u.src_b;
      XOR: r.w_data = u.src_a ^ u.src_b;
      SADD: begin
        sum = int'($signed(u.src_a)) + int'($signed(u.src_b));
        if (sum > (1 << (DATA_W - 1)) - 1) begin
          r.w_data = DATA_W'((1 << (DATA_W - 1)) - 1);
          r.vsaturate = 1'b1;
        end else if (sum < -(1 << (DATA_W - 1))) begin
          r.w_data = DATA_W'(-(1 << (DATA_W - 1)));
          r.vsaturate = 1'b1;
        end else begin
          r.w_data = DATA_W'(sum);
        end
      end
      MUL: begin
        prod = (2 * DATA_W)'(u.src_a) * (2 * DATA_W)'(u.src_b);
        r.w_data = prod[DATA_W-1:0];
      end
      default: r.w_data = '0;
    endcase
    return r;
  endfunction

  function automatic uop_t make_uop(uop_op_e op, logic [DATA_W-1:0] a, logic [DATA_W-1:0] b);
    uop_t u;
    u.op = op;
    u.vd = VREG_W'(3);
    u.src_a = a;
    u.src_b = b;
    u.w_valid = 1'b1;
    return u;
  endfunction

  function automatic uop_t random_uop();
    uop_t    u;
    uop_op_e ops [6];
    ops = '{ADD, SUB, AND, XOR, SADD, MUL};
    u.op = ops[$urandom_range(5)];
    u.vd = VREG_W'($urandom);
    u.src_a = DATA_W'($urandom);
    u.src_b = DATA_W'($urandom);
    u.w_valid = ($urandom_range(3) != 0);
    return u;
  endfunction

  // trap a record that is already in the ROB and not retiring this cycle
  task automatic choose_trap();
    int n_take;
    int idx;
    n_take = 0;
    for (int i = 0; i < RT_WIDTH; i++) begin
      if (n_take == i && rt_valid[i] && rt_ready[i]) n_take++;
    end
    if (exp_q.size() >= n_take + 2) begin
      idx = n_take + int'($urandom_range(exp_q.size() - 2 - n_take));
      trap.trap_rob_entry = exp_q[idx].entry;
      trap_valid = 1'b1;
    end
  endtask

  // advance to the next falling edge and drive the retire and trap side
  task automatic next_cycle();
    int pick;
    @(negedge clk);
    case (rt_mode)
      RT_LOW:  rt_ready = '0;
      RT_HIGH: rt_ready = '1;
      default: begin
        pick = $urandom_range(RT_WIDTH);
        rt_ready = RT_WIDTH'((1 << pick) - 1);
      end
    endcase
    trap_valid = 1'b0;
    if (trap_rate > 0 && $urandom_range(trap_rate - 1) == 0) choose_trap();
  endtask

  task automatic send_uop(input uop_t u);
    int   waited;
    logic taken;
    waited = 0;
    taken = 1'b0;
    uop_valid = 1'b1;
    uop = u;
    // the transfer is decided at the rising edge where the DUT sees it
    while (!taken && waited < UOP_TIMEOUT) begin
      @(posedge clk);
      taken = uop_ready;
      next_cycle();
      waited++;
    end
    if (!taken) begin
      $display("timeout at %0t: uop_ready stayed low", $time);
      announce_fail();
      $fatal(1);
    end
    uop_valid = 1'b0;
  endtask

  task automatic wait_empty(input int limit);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < limit) begin
      next_cycle();
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout at %0t: %0d expected records never retired", $time, exp_q.size());
      announce_fail();
      $fatal(1);
    end
  endtask

  // reference model following the handshakes at each rising edge
  always @(posedge clk) begin
    exp_t e;
    logic flushed;
    logic marked;
    int   taken;
    flushed = 1'b0;
    marked = 1'b0;
    taken = 0;
    if (!rst_n) begin
      exp_q.delete();
      next_entry = '0;
    end else begin
      for (int i = 0; i < RT_WIDTH; i++) begin
        if (rt_valid[i] && rt_ready[i] && exp_q.size() > 0) begin
          e = exp_q.pop_front();
          taken++;
          if (e.rec.trap_flag) flushed = 1'b1;
        end
      end
      if (taken == RT_WIDTH) dual_seen++;
      // a retired trap drops all younger work and numbering restarts at 0
      if (flushed) begin
        exp_q.delete();
        next_entry = '0;
        trap_seen++;
      end
      if (trap_valid) begin
        for (int j = 0; j < exp_q.size(); j++) begin
          if (!marked && exp_q[j].entry == trap.trap_rob_entry) begin
            e = exp_q[j];
            e.rec.trap_flag = 1'b1;
            exp_q[j] = e;
            marked = 1'b1;
          end
        end
      end
      if (uop_valid && uop_ready) begin
        e.rec = expected_record(uop);
        e.entry = next_entry;
        next_entry = next_entry + ROB_IDX_W'(1);
        exp_q.push_back(e);
      end
    end
    for (int i = 0; i < RT_WIDTH; i++) begin
      exp_rec[i] <= (exp_q.size() > i) ? exp_q[i].rec : '0;
    end
    exp_cnt <= exp_q.size();
  end

  a_reset_rt_idle: assert property (
    @(posedge clk) $rose(rst_n) |-> rt_valid == '0
  ) else begin
    $display("MISMATCH time %0t signal rt_valid got %b expected %b",
             $time, $sampled(rt_valid), {RT_WIDTH{1'b0}});
    announce_fail();
    $fatal(1);
  end

  a_reset_ready: assert property (
    @(posedge clk) $rose(rst_n) |-> uop_ready
  ) else begin
    $display("MISMATCH time %0t signal uop_ready got %b expected 1",
             $time, $sampled(uop_ready));
    announce_fail();
    $fatal(1);
  end

  // trap notices are always taken
  a_trap_ready: assert property (
    @(posedge clk) disable iff (!rst_n)
    trap_ready
  ) else begin
    $display("MISMATCH time %0t signal trap_ready got %b expected 1",
             $time, $sampled(trap_ready));
    announce_fail();
    $fatal(1);
  end

  for (genvar i = 0; i < RT_WIDTH; i++) begin : gen_rt_chk
    a_rt_expected: assert property (
      @(posedge clk) disable iff (!rst_n)
      rt_valid[i] && rt_ready[i] |-> exp_cnt > i
    ) else begin
      $display("retire lane %0d at %0t gave a record that was not expected", i, $time);
      announce_fail();
      $fatal(1);
    end

    a_rt_record: assert property (
      @(posedge clk) disable iff (!rst_n)
      rt_valid[i] && rt_ready[i] && exp_cnt > i |-> rt_rec[i] == exp_rec[i]
    ) else begin
      $display("MISMATCH time %0t signal rt_rec[%0d] got %h expected %h",
               $time, i, $sampled(rt_rec[i]), $sampled(exp_rec[i]));
      announce_fail();
      $fatal(1);
    end
  end

  initial begin
    int acc;
    int waited;
    int dual_before;
    int traps_before;
    void'($urandom(32'hff1a_3a06));
    rst_n = 1'b0;
    uop_valid = 1'b0;
    uop = '0;
    rt_ready = '0;
    trap_valid = 1'b0;
    trap = '0;
    rt_mode = RT_LOW;
    trap_rate = 0;
    dual_seen = 0;
    trap_seen = 0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    // random mix where MUL against one-cycle ops finishes out of order
    rt_mode = RT_HIGH;
    next_cycle();
    repeat (60) send_uop(random_uop());
    wait_empty(200);

    // saturating add in both directions and two sums that fit
    send_uop(make_uop(SADD, 16'h7000, 16'h2000));
    send_uop(make_uop(SADD, 16'h8000, 16'hffff));
    send_uop(make_uop(SADD, 16'h1234, 16'h0100));
    send_uop(make_uop(SADD, 16'hfff0, 16'h0008));
    wait_empty(50);

    // fill the ROB with retire held off
    rt_mode = RT_LOW;
    next_cycle();
    acc = 0;
    waited = 0;
    while (uop_ready && waited < 4 * ROB_DEPTH) begin
      send_uop(make_uop(XOR, DATA_W'($urandom), DATA_W'($urandom)));
      acc++;
      waited++;
    end
    assert (!uop_ready && acc >= ROB_DEPTH) else begin
      $display("back-pressure wrong: %0d uops accepted, uop_ready %b", acc, uop_ready);
      announce_fail();
      $fatal(1);
    end
    dual_before = dual_seen;
    rt_mode = RT_HIGH;
    wait_empty(100);
    assert (dual_seen > dual_before) else begin
      $display("no cycle retired two records while draining a full ROB");
      announce_fail();
      $fatal(1);
    end

    // trap the third of five waiting entries
    rt_mode = RT_LOW;
    next_cycle();
    repeat (5) send_uop(make_uop(ADD, DATA_W'($urandom), DATA_W'($urandom)));
    waited = 0;
    while (rt_valid != '1 && waited < 50) begin
      next_cycle();
      waited++;
    end
    assert (rt_valid == '1 && exp_q.size() == 5) else begin
      $display("entries not ready for the trap: rt_valid %b, %0d queued", rt_valid, exp_q.size());
      announce_fail();
      $fatal(1);
    end
    traps_before = trap_seen;
    trap.trap_rob_entry = exp_q[2].entry;
    trap_valid = 1'b1;
    rt_mode = RT_HIGH;
    next_cycle();
    waited = 0;
    while (trap_seen == traps_before && waited < 50) begin
      next_cycle();
      waited++;
    end
    assert (trap_seen == traps_before + 1) else begin
      $display("trapped entry never retired");
      announce_fail();
      $fatal(1);
    end
    // anything younger retiring now trips a_rt_expected
    repeat (8) next_cycle();
    send_uop(make_uop(MUL, DATA_W'($urandom), DATA_W'($urandom)));
    wait_empty(50);

    // random traps with random retire prefixes
    rt_mode = RT_RAND;
    trap_rate = 8;
    repeat (300) begin
      if ($urandom_range(3) == 0) next_cycle();
      else send_uop(random_uop());
    end
    trap_rate = 0;
    wait_empty(400);

    $display("Finished with no errors");
    $finish;
  end

endmodule
